// ==== vlog.f ====
design/apb_sub_pkg.sv
design/apb_bus_if.sv
design/ahb_apb_bridge.sv
design/table_bank.sv
design/apb_resp_collect.sv
design/apb_subsystem.sv
dv/apb_subsystem_asserts.sv
dv/apb_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module apb_subsystem_tb -o sim_tb

# Exit status of the simulation is the result of the run
./obj_dir/sim_tb

// ==== dv/apb_subsystem_tb.sv ====
/*
 * Testbench for the AHB-Lite to APB subsystem
 * AHB single transfers checked against a bank table model
 */

`timescale 1ns/1ps

module apb_subsystem_tb import apb_sub_pkg::*; ();

   localparam int    NUM_BANKS  = 4;
   localparam int    ENTRIES    = 16;
   localparam addr_t BASE_ADDR  = 32'h00A0_0000;
   // Tests take about 3600 cycles
   localparam int    MAX_CYCLES = 20000;

   logic    hclk;
   logic    arst_n;
   logic    hsel;
   addr_t   haddr;
   htrans_t htrans;
   logic    hwrite;
   data_t   hwdata;
   logic    hready_in;
   data_t   hrdata;
   logic    hready;
   hresp_t  hresp;

   // Expected table contents
   data_t model [NUM_BANKS][ENTRIES];
   int    cycles = 0;

   apb_subsystem #(
      .NUM_BANKS (NUM_BANKS),
      .ENTRIES   (ENTRIES),
      .BASE_ADDR (BASE_ADDR)
   ) apb_subsystem_i (.*);

   always #2 hclk = ~hclk;

   always @(posedge hclk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Test failures found");
         $fatal(1, "Timeout, run did not finish within %0d cycles", MAX_CYCLES);
      end
   end

   // ----------------------------------------------------------------------
   // Reference model and checks
   // ----------------------------------------------------------------------

   // Bank from bits 19:16 and entry from the word address mod ENTRIES
   // Returns 1 only for an address inside the mapped window
   function automatic bit ref_index(input addr_t a, output int bank, output int entry);
      bank  = int'(a[19:16]);
      entry = int'(a[15:0] >> 2) % ENTRIES;
      return (a[31:20] == BASE_ADDR[31:20]) && (bank < NUM_BANKS);
   endfunction

   function automatic addr_t entry_addr(input int bank, input int entry);
      return BASE_ADDR | (addr_t'(bank) << 16) | (addr_t'(entry) << 2);
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Test failures found");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // ----------------------------------------------------------------------
   // AHB driver tasks
   // ----------------------------------------------------------------------

   // Entered and left 1 ns after a rising edge
   task automatic run_transfer(input addr_t a, input logic wr, input data_t wd,
                               output data_t rd, output hresp_t resp);
      hsel      = 1'b1;
      haddr     = a;
      htrans    = HTRANS_NONSEQ;
      hwrite    = wr;
      hready_in = 1'b1;
      // Address phase is taken at the first edge with hready high
      while (!hready) begin
         @(posedge hclk);
         #1;
      end
      @(posedge hclk);
      #1;
      // Data phase
      hsel   = 1'b0;
      htrans = HTRANS_IDLE;
      if (wr) begin
         hwdata = wd;
      end
      while (!hready) begin
         @(posedge hclk);
         #1;
      end
      rd   = hrdata;
      resp = hresp;
   endtask

   task automatic ahb_write(input addr_t a, input data_t d);
      data_t  rd;
      hresp_t resp;
      int     bank;
      int     entry;
      run_transfer(a, 1'b1, d, rd, resp);
      if (ref_index(a, bank, entry)) begin
         check_value("hresp", 32'(resp), 32'(HRESP_OKAY));
         model[bank][entry] = d;
      end else begin
         check_value("hresp", 32'(resp), 32'(HRESP_ERROR));
      end
   endtask

   task automatic ahb_read(input addr_t a);
      data_t  rd;
      hresp_t resp;
      int     bank;
      int     entry;
      run_transfer(a, 1'b0, '0, rd, resp);
      if (ref_index(a, bank, entry)) begin
         check_value("hresp", 32'(resp), 32'(HRESP_OKAY));
         check_value($sformatf("hrdata @%h", a), rd, model[bank][entry]);
      end else begin
         check_value("hresp", 32'(resp), 32'(HRESP_ERROR));
      end
   endtask

   task automatic read_all();
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int e = 0; e < ENTRIES; e++) begin
            ahb_read(entry_addr(b, e));
         end
      end
   endtask

   // Bus activity that must not start a transfer
   task automatic drive_noise(input int n);
      repeat (n) begin
         hsel      = 1'b1;
         haddr     = entry_addr($urandom_range(NUM_BANKS - 1, 0), $urandom_range(ENTRIES - 1, 0));
         htrans    = HTRANS_NONSEQ;
         hwrite    = 1'b1;
         hwdata    = $urandom;
         hready_in = 1'b1;
         case ($urandom_range(3, 0))
            0: htrans = HTRANS_IDLE;
            1: htrans = HTRANS_BUSY;
            2: hsel = 1'b0;
            default: hready_in = 1'b0;
         endcase
         @(posedge hclk);
         #1;
      end
      hsel      = 1'b0;
      htrans    = HTRANS_IDLE;
      hready_in = 1'b1;
   endtask

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------

   initial begin
      addr_t rnd_addr;
      void'($urandom(32'h3d357804));
      hclk      = 1'b0;
      arst_n    = 1'b0;
      hsel      = 1'b0;
      haddr     = '0;
      htrans    = HTRANS_IDLE;
      hwrite    = 1'b0;
      hwdata    = '0;
      hready_in = 1'b1;
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int e = 0; e < ENTRIES; e++) begin
            model[b][e] = '0;
         end
      end
      repeat (5) @(posedge hclk);
      #1;
      arst_n = 1'b1;
      @(posedge hclk);
      #1;

      // Idle bus and cleared tables after reset
      check_value("hready", 32'(hready), 32'd1);
      check_value("hresp", 32'(hresp), 32'(HRESP_OKAY));
      read_all();

      // Distinct word in every entry
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int e = 0; e < ENTRIES; e++) begin
            ahb_write(entry_addr(b, e), {8'hC3, 8'(b), 16'(e * 257)});
         end
      end
      read_all();

      // Random mix where upper offset bits alias onto the entry
      repeat (400) begin
         rnd_addr = {BASE_ADDR[31:20], 4'($urandom_range(NUM_BANKS - 1, 0)),
                     16'($urandom) & 16'hFFFC};
         if ($urandom_range(1, 0) == 1) begin
            ahb_write(rnd_addr, $urandom);
         end else begin
            ahb_read(rnd_addr);
         end
      end

      // Outside the window and unused bank slots
      ahb_write(BASE_ADDR + 32'h0010_0000, $urandom);
      ahb_write(32'h0000_0040, $urandom);
      ahb_read(BASE_ADDR - 32'h0000_0004);
      for (int b = NUM_BANKS; b < 16; b++) begin
         ahb_write({BASE_ADDR[31:20], 4'(b), 16'h0008}, $urandom);
         ahb_read({BASE_ADDR[31:20], 4'(b), 16'h0008});
      end
      read_all();

      // IDLE, BUSY, no select and hready_in low leave tables alone
      drive_noise(60);
      read_all();

      // Same entry of every bank after each single-bank write
      for (int b = 0; b < NUM_BANKS; b++) begin
         ahb_write(entry_addr(b, 5), $urandom);
         for (int c = 0; c < NUM_BANKS; c++) begin
            ahb_read(entry_addr(c, 5));
         end
      end

      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== dv/apb_subsystem_asserts.sv ====
/*
 * Bridge protocol assertions
 * APB select, setup and hold rules and the two-cycle AHB error
 */

`timescale 1ns/1ps

module apb_subsystem_asserts import apb_sub_pkg::*; #(
   parameter int NUM_BANKS = 4
) (
   input logic                 hclk,
   input logic                 arst_n,
   input logic                 hready,
   input hresp_t               hresp,
   input logic [NUM_BANKS-1:0] psel,
   input logic                 penable,
   input logic                 pwrite,
   input addr_t                paddr,
   input data_t                pwdata,
   input logic                 pready
);

   // At most one bank selected
   a_psel_onehot: assert property (@(posedge hclk) disable iff (!arst_n) $onehot0(psel))
      else $error("psel has more than one bank selected");

   // Access phase only after a setup cycle
   a_setup_first: assert property (@(posedge hclk) disable iff (!arst_n)
      $rose(penable) |-> $past(|psel))
      else $error("penable rose without a setup cycle");

   // Request held while the bank inserts wait states
   a_req_stable: assert property (@(posedge hclk) disable iff (!arst_n)
      (penable && !pready) |=> (penable && $stable(psel) && $stable(paddr) &&
                                $stable(pwrite) && $stable(pwdata)))
      else $error("APB request changed while pready was low");

   // Error response, hready low then high
   a_err_two_cycle: assert property (@(posedge hclk) disable iff (!arst_n)
      ((hresp == HRESP_ERROR) && !hready) |=> ((hresp == HRESP_ERROR) && hready))
      else $error("ERROR response did not complete in its second cycle");

endmodule

// Attached inside every bridge instance
bind ahb_apb_bridge apb_subsystem_asserts #(.NUM_BANKS(NUM_BANKS)) u_asserts (
   .hclk    (hclk),
   .arst_n  (arst_n),
   .hready  (hready),
   .hresp   (hresp),
   .psel    (apb.psel),
   .penable (apb.penable),
   .pwrite  (apb.pwrite),
   .paddr   (apb.paddr),
   .pwdata  (apb.pwdata),
   .pready  (apb.pready)
);

// ==== design/apb_subsystem.sv ====
/*
 * AHB-Lite to APB peripheral subsystem
 * Bridge, NUM_BANKS table banks and the response collector
 */

`timescale 1ns/1ps

module apb_subsystem import apb_sub_pkg::*; #(
   parameter int    NUM_BANKS = 4,
   parameter int    ENTRIES   = 16,
   parameter addr_t BASE_ADDR = 32'h00A0_0000
) (
   input  logic    hclk,
   input  logic    arst_n,
   // AHB-Lite slave port
   input  logic    hsel,
   input  addr_t   haddr,
   input  htrans_t htrans,
   input  logic    hwrite,
   input  data_t   hwdata,
   input  logic    hready_in,
   output data_t   hrdata,
   output logic    hready,
   output hresp_t  hresp
);

   // Per-bank responses into the collector
   data_t                bank_rdata [NUM_BANKS];
   logic [NUM_BANKS-1:0] bank_ready;

   apb_bus_if #(.NUM_BANKS(NUM_BANKS)) apb_bus ();

   // ----------------------------------------------------------------------
   // Bridge
   // ----------------------------------------------------------------------

   ahb_apb_bridge #(
      .NUM_BANKS (NUM_BANKS),
      .BASE_ADDR (BASE_ADDR)
   ) u_bridge (
      .hclk      (hclk),
      .arst_n    (arst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .apb       (apb_bus)
   );

   // ----------------------------------------------------------------------
   // Banks, one per APB slot
   // ----------------------------------------------------------------------

   for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank
      table_bank #(
         .ENTRIES (ENTRIES)
      ) u_bank (
         .hclk       (hclk),
         .arst_n     (arst_n),
         .psel       (apb_bus.psel[g]),
         .apb        (apb_bus),
         .bank_rdata (bank_rdata[g]),
         .bank_ready (bank_ready[g])
      );
   end

   // Merged response back to the bridge
   apb_resp_collect #(
      .NUM_BANKS (NUM_BANKS)
   ) u_collect (
      .bank_rdata (bank_rdata),
      .bank_ready (bank_ready),
      .apb        (apb_bus)
   );

endmodule

// ==== design/apb_resp_collect.sv ====
/*
 * APB response collector
 * Returns read data and ready of the bank whose select is set
 */

`timescale 1ns/1ps

module apb_resp_collect import apb_sub_pkg::*; #(
   parameter int NUM_BANKS = 4
) (
   // Per-bank responses
   input  data_t                bank_rdata [NUM_BANKS],
   input  logic [NUM_BANKS-1:0] bank_ready,
   apb_bus_if.collect           apb
);

   // ----------------------------------------------------------------------
   // Select mux
   // ----------------------------------------------------------------------

   // psel is one-hot, so at most one bank matches
   always_comb begin
      apb.prdata = '0;
      // No bank selected means not ready
      apb.pready = 1'b0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         if (apb.psel[i]) begin
            apb.prdata = bank_rdata[i];
            apb.pready = bank_ready[i];
         end
      end
   end

endmodule

// ==== design/table_bank.sv ====
/*
 * APB register table bank
 * ENTRIES words, written in the first access cycle, read back
 * with one wait state from a latched word
 */

`timescale 1ns/1ps

module table_bank import apb_sub_pkg::*; #(
   parameter int ENTRIES = 16
) (
   input  logic hclk,
   input  logic arst_n,
   // Select bit of this bank
   input  logic psel,
   apb_bus_if.bank apb,
   output data_t bank_rdata,
   output logic  bank_ready
);

   localparam int IDX_W = $clog2(ENTRIES);

   // Word index, upper offset bits alias
   logic [IDX_W-1:0] idx;

   logic  wr_access;
   logic  rd_access;

   // Set in the first access cycle of a read
   logic  rd_pend;

   // Word latched for the second access cycle
   data_t rdata_q;

   data_t table_q [ENTRIES];

   // ----------------------------------------------------------------------
   // Decode
   // ----------------------------------------------------------------------

   assign idx = apb.paddr[IDX_W+1:2];

   assign wr_access = psel && apb.penable && apb.pwrite;
   assign rd_access = psel && apb.penable && !apb.pwrite;

   // ----------------------------------------------------------------------
   // Table storage
   // ----------------------------------------------------------------------

   // Cleared so that reads after reset return zero
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < ENTRIES; i++) begin
            table_q[i] <= '0;
         end
      end else if (wr_access) begin
         table_q[idx] <= apb.pwdata;
      end
   end

   // ----------------------------------------------------------------------
   // Read wait state
   // ----------------------------------------------------------------------

   // High only in the second access cycle of a read
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= rd_access && !rd_pend;
      end
   end

   always_ff @(posedge hclk) begin
      if (rd_access && !rd_pend) begin
         rdata_q <= table_q[idx];
      end
   end

   // Writes finish at once, reads one cycle later
   assign bank_ready = wr_access || (rd_access && rd_pend);

   // Zero when another bank owns the bus
   assign bank_rdata = psel ? rdata_q : '0;

endmodule

// ==== design/ahb_apb_bridge.sv ====
/*
 * AHB-Lite slave to APB master bridge
 * Registers single transfers, decodes the bank window and runs
 * the APB setup and access phases, one transfer at a time
 */

`timescale 1ns/1ps

module ahb_apb_bridge import apb_sub_pkg::*; #(
   parameter int    NUM_BANKS = 4,
   parameter addr_t BASE_ADDR = 32'h00A0_0000
) (
   input  logic    hclk,
   input  logic    arst_n,
   // AHB-Lite slave side
   input  logic    hsel,
   input  addr_t   haddr,
   input  htrans_t htrans,
   input  logic    hwrite,
   input  data_t   hwdata,
   input  logic    hready_in,
   output data_t   hrdata,
   output logic    hready,
   output hresp_t  hresp,
   // APB master side
   apb_bus_if.bridge apb
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS,
      ST_DONE,
      ST_ERR1,
      ST_ERR2
   } state_t;

   state_t state_q;
   state_t state_d;

   logic   addr_phase;
   logic   accept;
   logic   in_window;

   // Registered address phase
   addr_t  addr_q;
   logic   write_q;
   logic   [3:0] bank_q;
   data_t  wdata_q;

   // ----------------------------------------------------------------------
   // Address phase and decode
   // ----------------------------------------------------------------------

   // Only NONSEQ and SEQ start a transfer, IDLE and BUSY are ignored
   assign addr_phase = hsel && hready_in &&
                       ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

   // Sampled only while this slave is not stalling the bus
   assign accept = addr_phase && hready;

   // 1 MB window, bank from bits 19:16, unused banks unmapped
   assign in_window = (haddr[31:20] == BASE_ADDR[31:20]) &&
                      (32'(haddr[19:16]) < NUM_BANKS);

   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q  <= haddr;
         write_q <= hwrite;
         bank_q  <= haddr[19:16];
      end
   end

   // hwdata arrives in the data phase, which is the setup cycle
   always_ff @(posedge hclk) begin
      if (state_q == ST_SETUP) begin
         wdata_q <= hwdata;
      end
   end

   // ----------------------------------------------------------------------
   // Transfer FSM
   // ----------------------------------------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         // Second error cycle has hready high and may take a new transfer
         ST_IDLE, ST_ERR2: begin
            if (accept) begin
               state_d = in_window ? ST_SETUP : ST_ERR1;
            end else begin
               state_d = ST_IDLE;
            end
         end
         ST_SETUP: state_d = ST_ACCESS;
         // Wait states from the bank extend this phase
         ST_ACCESS: begin
            if (apb.pready) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: state_d = ST_IDLE;
         ST_ERR1: state_d = ST_ERR2;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Read data held until the next read completes
   always_ff @(posedge hclk) begin
      if ((state_q == ST_ACCESS) && apb.pready && !write_q) begin
         hrdata <= apb.prdata;
      end
   end

   // ----------------------------------------------------------------------
   // Outputs
   // ----------------------------------------------------------------------

   // AHB side
   assign hready = (state_q == ST_IDLE) || (state_q == ST_ERR2);
   assign hresp  = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ?
                   HRESP_ERROR : HRESP_OKAY;

   // APB request, held stable through setup and access
   assign apb.paddr   = addr_q;
   assign apb.pwrite  = write_q;
   assign apb.penable = (state_q == ST_ACCESS);
   assign apb.pwdata  = (state_q == ST_SETUP) ? hwdata : wdata_q;

   // One-hot select of the decoded bank
   always_comb begin
      for (int i = 0; i < NUM_BANKS; i++) begin
         apb.psel[i] = ((state_q == ST_SETUP) || (state_q == ST_ACCESS)) &&
                       (bank_q == 4'(i));
      end
   end

endmodule

// ==== design/apb_bus_if.sv ====
/*
 * APB bus between the bridge and the table banks
 * Carries the request from the bridge and the merged response
 * from the collector
 */

`timescale 1ns/1ps

interface apb_bus_if import apb_sub_pkg::*; #(
   parameter int NUM_BANKS = 4
);

   // Request, driven by the bridge
   addr_t                paddr;
   logic                 pwrite;
   logic                 penable;
   data_t                pwdata;
   // One select bit per bank
   logic [NUM_BANKS-1:0] psel;

   // Response of the selected bank
   data_t                prdata;
   logic                 pready;

   modport bridge (
      output paddr, pwrite, penable, pwdata, psel,
      input  prdata, pready
   );

   // Each bank gets its psel bit as a separate port
   modport bank (
      input paddr, pwrite, penable, pwdata
   );

   modport collect (
      input  psel,
      output prdata, pready
   );

endinterface

// ==== design/apb_sub_pkg.sv ====
/*
 * APB subsystem shared definitions
 * Bus vector types and AHB-Lite encodings used by the bridge,
 * the APB bus interface and the table banks
 */

package apb_sub_pkg;

   // ----------------------------------------------------------------------
   // Bus vectors
   // ----------------------------------------------------------------------

   // Byte address on both AHB and APB sides
   typedef logic [31:0] addr_t;

   // One bus data word
   typedef logic [31:0] data_t;

   // ----------------------------------------------------------------------
   // AHB-Lite encodings
   // ----------------------------------------------------------------------

   // Transfer type as driven on htrans
   typedef logic [1:0] htrans_t;

   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;
   // First beat or single transfer
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   // Later beats of a burst, handled as singles here
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   // Slave response on hresp
   typedef logic [1:0] hresp_t;

   localparam hresp_t HRESP_OKAY  = 2'b00;
   // Two-cycle response, first cycle with hready low
   localparam hresp_t HRESP_ERROR = 2'b01;

endpackage
